// File: Makefile
# Verilator build and run for the memory stage testbench

VERILATOR ?= verilator
TOP       ?= mem_stage_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rtl/load_extend.sv
// load data alignment and extension for the memory stage
// picks byte, halfword or word from the four lanes, purely combinational

`timescale 1ns/1ps

module load_extend import mem_stage_pkg::*; (
    input  mem_op_e                   i_load_op,
    input  logic [1:0]                i_byte_off,
    input  logic [NUM_LANES-1:0][7:0] i_lane_rdata,
    output logic [XLEN-1:0]           o_mem_data
);

    logic [7:0]  load_byte;
    logic [15:0] load_half;

    // addressed byte
    assign load_byte = i_lane_rdata[i_byte_off];

    // halfword is always even aligned here, bit 1 picks the pair
    assign load_half = i_byte_off[1] ? {i_lane_rdata[3], i_lane_rdata[2]}
                                     : {i_lane_rdata[1], i_lane_rdata[0]};

    always_comb begin
        case (i_load_op)
            MEM_LB: begin
                // sign extend byte
                o_mem_data = {{(XLEN-8){load_byte[7]}}, load_byte};
            end
            MEM_LH: begin
                // sign extend halfword
                o_mem_data = {{(XLEN-16){load_half[15]}}, load_half};
            end
            MEM_LW: begin
                o_mem_data = i_lane_rdata;
            end
            MEM_LBU: begin
                o_mem_data = {{(XLEN-8){1'b0}}, load_byte};
            end
            MEM_LHU: begin
                o_mem_data = {{(XLEN-16){1'b0}}, load_half};
            end
            default: begin
                // stores, no-ops and cancelled loads
                o_mem_data = '0;
            end
        endcase
    end

endmodule

// File: rtl/mem_access_ctrl.sv
// address generation and byte-lane control for the memory stage
// two register stages: operand capture, then bank/extend controls

`timescale 1ns/1ps

module mem_access_ctrl import mem_stage_pkg::*; #(
    parameter int DEPTH_WORDS = 256
) (
    input  logic                              clk,
    input  logic                              nrst,
    input  mem_op_e                           i_mem_op,
    input  logic [XLEN-1:0]                   i_op_a,
    input  logic [XLEN-1:0]                   i_op_b,
    input  logic [XLEN-1:0]                   i_s_imm,
    output logic [NUM_LANES-1:0]              o_lane_we,
    output logic [$clog2(DEPTH_WORDS)-1:0]    o_word_idx,
    output logic [NUM_LANES-1:0][7:0]         o_lane_wdata,
    output mem_op_e                           o_load_op,
    output logic [1:0]                        o_byte_off,
    output logic                              o_addr_misaligned
);

    localparam int IDX_W = $clog2(DEPTH_WORDS);

    // first stage registers
    mem_op_e                   mem_op_q;
    logic [XLEN-1:0]           op_a_q;
    logic [XLEN-1:0]           op_b_q;
    logic [XLEN-1:0]           s_imm_q;

    // first stage decode
    logic                      is_store;
    logic [XLEN-1:0]           addr;
    logic                      is_byte;
    logic                      is_half;
    logic                      is_word;
    logic                      misaligned;
    logic [NUM_LANES-1:0]      lane_we_d;
    logic [NUM_LANES-1:0][7:0] lane_wdata_d;
    mem_op_e                   load_op_d;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            mem_op_q <= MEM_NONE;
            op_a_q   <= '0;
            op_b_q   <= '0;
            s_imm_q  <= '0;
        end else begin
            mem_op_q <= i_mem_op;
            op_a_q   <= i_op_a;
            op_b_q   <= i_op_b;
            s_imm_q  <= i_s_imm;
        end
    end

    // stores use the S offset, loads the I offset carried in op_b
    assign is_store = mem_op_q[3];
    assign addr     = op_a_q + (is_store ? s_imm_q : op_b_q);

    // access size classes
    always_comb begin
        is_byte = 1'b0;
        is_half = 1'b0;
        is_word = 1'b0;
        case (mem_op_q)
            MEM_LB, MEM_LBU, MEM_SB: is_byte = 1'b1;
            MEM_LH, MEM_LHU, MEM_SH: is_half = 1'b1;
            MEM_LW, MEM_SW:          is_word = 1'b1;
            default: ;
        endcase
    end

    // halfword needs bit 0 clear, word needs both low bits clear
    assign misaligned = (is_half & addr[0]) | (is_word & (addr[1] | addr[0]));

    // lane enables and store data steering
    always_comb begin
        lane_we_d    = '0;
        lane_wdata_d = op_b_q;
        if (is_store && !misaligned) begin
            if (is_word) begin
                lane_we_d = '1;
            end else if (is_half) begin
                // upper or lower lane pair by address bit 1
                lane_we_d    = addr[1] ? 4'b1100 : 4'b0011;
                lane_wdata_d = {2{op_b_q[15:0]}};
            end else if (is_byte) begin
                lane_we_d    = 4'b0001 << addr[1:0];
                lane_wdata_d = {NUM_LANES{op_b_q[7:0]}};
            end
        end
    end

    // loads only, misaligned ones cancelled
    assign load_op_d = (is_store || misaligned) ? MEM_NONE : mem_op_q;

    // second stage, feeds banks and extender directly
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            o_lane_we         <= '0;
            o_word_idx        <= '0;
            o_lane_wdata      <= '0;
            o_load_op         <= MEM_NONE;
            o_byte_off        <= '0;
            o_addr_misaligned <= 1'b0;
        end else begin
            o_lane_we         <= lane_we_d;
            // word index wraps modulo the memory depth
            o_word_idx        <= addr[IDX_W+1:2];
            o_lane_wdata      <= lane_wdata_d;
            o_load_op         <= load_op_d;
            o_byte_off        <= addr[1:0];
            o_addr_misaligned <= misaligned;
        end
    end

endmodule

// File: rtl/mem_byte_bank.sv
// one byte lane of the data memory, holding that lane of every word
// clocked write, combinational read at the row index

`timescale 1ns/1ps

module mem_byte_bank import mem_stage_pkg::*; #(
    parameter int DEPTH_WORDS = 256
) (
    input  logic                           clk,
    input  logic                           i_we,
    input  logic [$clog2(DEPTH_WORDS)-1:0] i_word_idx,
    input  logic [XLEN/NUM_LANES-1:0]      i_wdata,
    output logic [XLEN/NUM_LANES-1:0]      o_rdata
);

    localparam int BYTE_W = XLEN / NUM_LANES;

    // lane storage, contents undefined until written
    logic [BYTE_W-1:0] mem [DEPTH_WORDS];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_word_idx] <= i_wdata;
        end
    end

    // same-cycle read, sees a write from the previous edge
    assign o_rdata = mem[i_word_idx];

endmodule

// File: rtl/mem_stage.sv
// memory stage top: access controller, byte-lane banks and load extender
// fixed two-cycle latency, one operation accepted every cycle

`timescale 1ns/1ps

module mem_stage import mem_stage_pkg::*; #(
    parameter int DEPTH_WORDS = 256
) (
    input  logic            clk,
    input  logic            nrst,
    input  mem_op_e         i_mem_op,
    input  logic [XLEN-1:0] i_op_a,
    input  logic [XLEN-1:0] i_op_b,
    input  logic [XLEN-1:0] i_s_imm,
    output logic [XLEN-1:0] o_mem_data,
    output logic            o_addr_misaligned
);

    localparam int IDX_W = $clog2(DEPTH_WORDS);

    // controller to banks and extender
    logic [NUM_LANES-1:0]      lane_we;
    logic [IDX_W-1:0]          word_idx;
    logic [NUM_LANES-1:0][7:0] lane_wdata;
    logic [NUM_LANES-1:0][7:0] lane_rdata;
    mem_op_e                   load_op;
    logic [1:0]                byte_off;

    mem_access_ctrl #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) u_ctrl (
        .clk               (clk),
        .nrst              (nrst),
        .i_mem_op          (i_mem_op),
        .i_op_a            (i_op_a),
        .i_op_b            (i_op_b),
        .i_s_imm           (i_s_imm),
        .o_lane_we         (lane_we),
        .o_word_idx        (word_idx),
        .o_lane_wdata      (lane_wdata),
        .o_load_op         (load_op),
        .o_byte_off        (byte_off),
        .o_addr_misaligned (o_addr_misaligned)
    );

    // one bank per byte lane, all share the row index
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        mem_byte_bank #(
            .DEPTH_WORDS (DEPTH_WORDS)
        ) u_bank (
            .clk        (clk),
            .i_we       (lane_we[k]),
            .i_word_idx (word_idx),
            .i_wdata    (lane_wdata[k]),
            .o_rdata    (lane_rdata[k])
        );
    end

    load_extend u_extend (
        .i_load_op    (load_op),
        .i_byte_off   (byte_off),
        .i_lane_rdata (lane_rdata),
        .o_mem_data   (o_mem_data)
    );

endmodule

// File: rtl/mem_stage_pkg.sv
// shared width constants and the memory operation encoding for the memory stage
// import with a wildcard in the module header of any file that needs them

package mem_stage_pkg;

    // data and address width
    localparam int XLEN = 32;

    // byte lanes per data word
    localparam int NUM_LANES = XLEN / 8;

    // memory operation codes, fixed by the decoder
    // bit 3 set marks a store
    typedef enum logic [3:0] {
        // no memory access this cycle
        MEM_NONE = 4'd0,
        // signed byte load
        MEM_LB   = 4'd1,
        // signed halfword load
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        // unsigned byte load
        MEM_LBU  = 4'd4,
        // unsigned halfword load
        MEM_LHU  = 4'd5,
        MEM_SW   = 4'd8,
        MEM_SB   = 4'd14,
        MEM_SH   = 4'd15
    } mem_op_e;

endpackage

// File: tb.f
rtl/mem_stage_pkg.sv
rtl/mem_access_ctrl.sv
rtl/mem_byte_bank.sv
rtl/load_extend.sv
rtl/mem_stage.sv
testbench/tb_clock_gen.sv
testbench/mem_stage_tb.sv

// File: testbench/mem_stage_tb.sv
// self-checking testbench for the memory stage
// byte-array reference model, results compared two falling edges after issue

`timescale 1ns/1ps

module mem_stage_tb import mem_stage_pkg::*;;

    localparam int  CLK_PERIOD   = 40;
    localparam int  RESET_CYCLES = 8;
    localparam int  DEPTH_WORDS  = 256;
    localparam int  ADDR_BITS    = $clog2(DEPTH_WORDS * 4);
    localparam int  MEM_BYTES    = DEPTH_WORDS * 4;
    // init fill, directed sections and random traffic
    localparam int  N_INIT       = DEPTH_WORDS;
    localparam int  N_DIRECTED   = 64;
    localparam int  N_RANDOM     = 400;
    localparam int  N_OPS        = N_INIT + N_DIRECTED + N_RANDOM;
    localparam int  WATCHDOG_NS  = (N_OPS + 20) * CLK_PERIOD;
    localparam time CHECK_DELAY  = 64'(2 * CLK_PERIOD);

    logic            clk;
    logic            nrst;
    mem_op_e         i_mem_op;
    logic [XLEN-1:0] i_op_a;
    logic [XLEN-1:0] i_op_b;
    logic [XLEN-1:0] i_s_imm;
    logic [XLEN-1:0] o_mem_data;
    logic            o_addr_misaligned;

    // reference memory, one entry per byte address
    logic [7:0]      model_mem [MEM_BYTES];

    // expected results waiting for their compare edge
    logic [XLEN-1:0] exp_data_q [$];
    logic            exp_mis_q  [$];
    string           name_q     [$];
    time             stamp_q    [$];

    integer          seed = 32'h1d0d20e5;

    tb_clock_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clk (
        .o_clk  (clk),
        .o_nrst (nrst)
    );

    mem_stage #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) dut (
        .clk               (clk),
        .nrst              (nrst),
        .i_mem_op          (i_mem_op),
        .i_op_a            (i_op_a),
        .i_op_b            (i_op_b),
        .i_s_imm           (i_s_imm),
        .o_mem_data        (o_mem_data),
        .o_addr_misaligned (o_addr_misaligned)
    );

    // expected load value and flag, stores applied to the byte array
    function automatic void model_access(
        input  mem_op_e         op,
        input  logic [XLEN-1:0] base,
        input  logic [XLEN-1:0] op_b,
        input  logic [XLEN-1:0] s_imm,
        output logic [XLEN-1:0] data,
        output logic            misaligned
    );
        logic                 is_st;
        logic [XLEN-1:0]      ea;
        logic [XLEN-1:0]      val;
        logic [ADDR_BITS-1:0] bidx;
        int                   nbytes;
        data       = '0;
        misaligned = 1'b0;
        is_st      = (op == MEM_SW) || (op == MEM_SB) || (op == MEM_SH);
        ea         = base + (is_st ? s_imm : op_b);
        case (op)
            MEM_LB, MEM_LBU, MEM_SB: nbytes = 1;
            MEM_LH, MEM_LHU, MEM_SH: nbytes = 2;
            MEM_LW, MEM_SW:          nbytes = 4;
            default:                 nbytes = 0;
        endcase
        if (nbytes == 0) begin
            return;
        end
        // natural alignment required
        misaligned = (ea % nbytes) != 0;
        if (misaligned) begin
            return;
        end
        val = '0;
        for (int i = 0; i < nbytes; i++) begin
            bidx = ea[ADDR_BITS-1:0] + ADDR_BITS'(i);
            if (is_st) begin
                model_mem[bidx] = op_b[8*i +: 8];
            end else begin
                val[8*i +: 8] = model_mem[bidx];
            end
        end
        if (op == MEM_LB && val[7]) begin
            val = val | 32'hffff_ff00;
        end
        if (op == MEM_LH && val[15]) begin
            val = val | 32'hffff_0000;
        end
        data = is_st ? '0 : val;
    endfunction

    task automatic check_data(input string name, input logic [XLEN-1:0] expected,
                              input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s o_mem_data expected %08h actual %08h",
                     name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "load data compare failed");
        end
    endtask

    task automatic check_misaligned(input string name, input logic expected,
                                    input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH %s o_addr_misaligned expected %0b actual %0b",
                     name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "misaligned flag compare failed");
        end
    endtask

    // one operation per falling edge, expected result queued with its issue time
    task automatic issue_op(input mem_op_e op, input logic [XLEN-1:0] base,
                            input logic [XLEN-1:0] op_b, input logic [XLEN-1:0] s_imm,
                            input string name);
        logic [XLEN-1:0] want_data;
        logic            want_mis;
        @(negedge clk);
        i_mem_op = op;
        i_op_a   = base;
        i_op_b   = op_b;
        i_s_imm  = s_imm;
        model_access(op, base, op_b, s_imm, want_data, want_mis);
        exp_data_q.push_back(want_data);
        exp_mis_q.push_back(want_mis);
        name_q.push_back(name);
        stamp_q.push_back($time);
    endtask

    // every word gets a value tied to its full address
    function automatic logic [XLEN-1:0] fill_word(input logic [XLEN-1:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'hc3a5_0f96;
    endfunction

    // 12-bit signed immediate
    function automatic logic [XLEN-1:0] rand_offset();
        logic [XLEN-1:0] r;
        r = $random(seed);
        return {{(XLEN-12){r[11]}}, r[11:0]};
    endfunction

    // compare whatever was issued two edges ago
    initial begin : compare_proc
        logic [XLEN-1:0] want_data;
        logic            want_mis;
        string           want_name;
        wait (nrst === 1'b1);
        forever begin
            @(negedge clk);
            while (stamp_q.size() != 0 && stamp_q[0] + CHECK_DELAY <= $time) begin
                want_data = exp_data_q.pop_front();
                want_mis  = exp_mis_q.pop_front();
                want_name = name_q.pop_front();
                void'(stamp_q.pop_front());
                check_data(want_name, want_data, o_mem_data);
                check_misaligned(want_name, want_mis, o_addr_misaligned);
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("simulation hung, no result after %0d ns", WATCHDOG_NS);
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        logic [XLEN-1:0] rt_addr [6];
        logic [7:0]      sign_bytes [4];
        logic [15:0]     sign_halves [2];
        mem_op_e         op_table [9];
        mem_op_e         op;
        logic [XLEN-1:0] wdata;
        logic [XLEN-1:0] base;
        logic [XLEN-1:0] r;
        int              pick;
        rt_addr     = '{32'h0, 32'h4, 32'h100, 32'h3fc, 32'h1238, 32'hffff_fff0};
        sign_bytes  = '{8'h80, 8'hff, 8'h7f, 8'h01};
        sign_halves = '{16'h8001, 16'h7ffe};
        op_table    = '{MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU,
                        MEM_LHU, MEM_SW, MEM_SB, MEM_SH};
        i_mem_op = MEM_NONE;
        i_op_a   = '0;
        i_op_b   = '0;
        i_s_imm  = '0;

        wait (nrst === 1'b1);
        @(negedge clk);
        check_data("reset", '0, o_mem_data);
        check_misaligned("reset", 1'b0, o_addr_misaligned);
        // idle ops with junk operands still return zero
        issue_op(MEM_NONE, $random(seed), $random(seed), $random(seed), "reset");
        issue_op(MEM_NONE, $random(seed), $random(seed), $random(seed), "reset");

        // banks power up undefined, so fill every word first
        for (int w = 0; w < N_INIT; w++) begin
            issue_op(MEM_SW, 32'(4 * w), fill_word(32'(4 * w)), '0, "init_fill");
        end

        // store then load on the next cycle, S offset then I offset
        for (int i = 0; i < 6; i++) begin
            wdata = $random(seed);
            issue_op(MEM_SW, rt_addr[i] - 12, wdata, 32'd12, "word_round_trip");
            issue_op(MEM_LW, rt_addr[i] + 8, 32'hffff_fff8, '0, "word_round_trip");
        end

        // byte stores at each lane, halfword stores at each pair
        for (int off = 0; off < 4; off++) begin
            issue_op(MEM_SB, 32'h80, $random(seed), 32'(off), "partial_stores");
            issue_op(MEM_LW, 32'h80, '0, '0, "partial_stores");
            issue_op(MEM_LBU, 32'h80, 32'(off), '0, "partial_stores");
            issue_op(MEM_LHU, 32'h80, 32'(off & 2), '0, "partial_stores");
        end
        for (int off = 0; off < 4; off += 2) begin
            issue_op(MEM_SH, 32'ha0, $random(seed), 32'(off), "partial_stores");
            issue_op(MEM_LW, 32'ha0, '0, '0, "partial_stores");
            issue_op(MEM_LHU, 32'ha0, 32'(off), '0, "partial_stores");
        end

        // top bit set and clear, upper operand bits are junk
        for (int i = 0; i < 4; i++) begin
            wdata      = $random(seed);
            wdata[7:0] = sign_bytes[i];
            issue_op(MEM_SB, 32'hc0, wdata, 32'(i), "sign_extension");
            issue_op(MEM_LB, 32'hc0, 32'(i), '0, "sign_extension");
            issue_op(MEM_LBU, 32'hc0, 32'(i), '0, "sign_extension");
        end
        for (int i = 0; i < 2; i++) begin
            wdata       = $random(seed);
            wdata[15:0] = sign_halves[i];
            issue_op(MEM_SH, 32'hc4, wdata, 32'(2 * i), "sign_extension");
            issue_op(MEM_LH, 32'hc4, 32'(2 * i), '0, "sign_extension");
            issue_op(MEM_LHU, 32'hc4, 32'(2 * i), '0, "sign_extension");
        end

        issue_op(MEM_LH, 32'he0, 32'd1, '0, "misaligned");
        issue_op(MEM_LHU, 32'he0, 32'd3, '0, "misaligned");
        issue_op(MEM_SH, 32'he0, 32'h1234_5678, 32'd1, "misaligned");
        issue_op(MEM_LW, 32'he0, 32'd2, '0, "misaligned");
        issue_op(MEM_SW, 32'he0, 32'hdead_beef, 32'd1, "misaligned");
        issue_op(MEM_SW, 32'he0, 32'hcafe_f00d, 32'd3, "misaligned");
        // word must still hold its fill value
        issue_op(MEM_LW, 32'he0, '0, '0, "misaligned");

        for (int n = 0; n < N_RANDOM; n++) begin
            pick = $unsigned($random(seed)) % 9;
            op   = op_table[pick];
            r    = $random(seed);
            base = $random(seed);
            // half the bases word aligned, else most accesses trap
            if (r[0]) begin
                base[1:0] = 2'b00;
            end
            if (op == MEM_SW || op == MEM_SB || op == MEM_SH || op == MEM_NONE) begin
                wdata = $random(seed);
            end else begin
                wdata = rand_offset();
            end
            issue_op(op, base, wdata, rand_offset(), "random_traffic");
        end

        issue_op(MEM_NONE, '0, '0, '0, "flush");
        issue_op(MEM_NONE, '0, '0, '0, "flush");
        while (stamp_q.size() != 0) begin
            @(negedge clk);
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: testbench/tb_clock_gen.sv
// clock and reset source for the memory stage testbench
// free-running clock, reset held low for a fixed number of cycles

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic o_clk,
    output logic o_nrst
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    // release on a falling edge, away from the capture edge
    initial begin
        o_nrst = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_nrst = 1'b1;
    end

endmodule
